/* console_rom.hex */
// console ROM image: one 16-bit hex word per line, word addresses 0 to 63
C03F
C13E
C23D
C33C
C43B
C53A
C639
C738
C837
C936
CA35
CB34
CC33
CD32
CE31
CF30
D02F
D12E
D22D
D32C
D42B
D52A
D629
D728
D827
D926
DA25
DB24
DC23
DD22
DE21
DF20
E01F
E11E
E21D
E31C
E41B
E51A
E619
E718
E817
E916
EA15
EB14
EC13
ED12
EE11
EF10
F00F
F10E
F20D
F30C
F40B
F50A
F609
F708
F807
F906
FA05
FB04
FC03
FD02
FE01
FF00

/* files.f */
+incdir+.
console_pkg.sv
clock_enable_gen.sv
address_decoder.sv
console_rom.sv
scratchpad_ram.sv
tone_generator.sv
console_board.sv
tb_console_board.sv

/* tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic report_error(input string what);
   error_count++;
   $display("ERROR at %0t ns: %s", $time, what);
endtask

task automatic check_word(input string name, input logic [DATA_BITS-1:0] expected,
                          input logic [DATA_BITS-1:0] actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
   end
endtask

task automatic check_audio(input string name, input logic signed [AUDIO_BITS-1:0] expected,
                           input logic signed [AUDIO_BITS-1:0] actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
   end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
   end
endtask

// follows audio_o through sign flips, first two flips only resync
task automatic measure_tone(input int amp, input int period);
   logic signed [AUDIO_BITS-1:0] last;
   int                           cycles;
   int                           limit;
   for (int flip = 0; flip < 6; flip++) begin
      last   = audio_o;
      cycles = 0;
      limit  = (flip < 2) ? 2 * (2 ** PERIOD_BITS) * SOUND_DIV : 2 * period * SOUND_DIV;
      while (audio_o === last && cycles < limit) begin
         next_cycle();
         cycles++;
      end
      if (audio_o === last) begin
         report_error("audio_o stopped toggling on the tone channel");
         return;
      end
      check_audio("audio_o", audio_o[AUDIO_BITS-1] ? AUDIO_BITS'(-amp) : AUDIO_BITS'(amp),
                  audio_o);
      if (flip >= 2) begin
         check_word("audio_o half period", DATA_BITS'(period * SOUND_DIV), DATA_BITS'(cycles));
      end
   end
endtask

`endif

/* tb_console_board.sv */
`timescale 1ns/1ns

module tb_console_board
   import console_pkg::*;
();

   logic                         clk;
   logic                         reset_i;
   logic                         memen_i;
   logic                         dbin_i;
   logic                         we_i;
   logic [ADDR_BITS-1:0]         addr_i;
   logic [DATA_BITS-1:0]         data_i;
   logic [DATA_BITS-1:0]         data_o;
   logic signed [AUDIO_BITS-1:0] audio_o;
   logic                         ready_o;
   logic                         sys_reset_o;
   logic                         cpu_clk_en_o;

   logic [DATA_BITS-1:0] rom_image [ROM_WORDS];
   logic [DATA_BITS-1:0] ram_shadow [RAM_WORDS];

   console_board dut_i (
      .clk          (clk),
      .reset_i      (reset_i),
      .memen_i      (memen_i),
      .dbin_i       (dbin_i),
      .we_i         (we_i),
      .addr_i       (addr_i),
      .data_i       (data_i),
      .data_o       (data_o),
      .audio_o      (audio_o),
      .ready_o      (ready_o),
      .sys_reset_o  (sys_reset_o),
      .cpu_clk_en_o (cpu_clk_en_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic next_cycle();
      @(posedge clk);
      #1; // inputs move 1 ns after the edge
   endtask

   `include "tb_checks.svh"

   task automatic bus_idle();
      memen_i = 1'b0;
      dbin_i  = 1'b0;
      we_i    = 1'b0;
   endtask

   // result sampled one cycle after the read is presented
   task automatic bus_read(input logic [ADDR_BITS-1:0] addr, output logic [DATA_BITS-1:0] data);
      memen_i = 1'b1;
      dbin_i  = 1'b1;
      we_i    = 1'b0;
      addr_i  = addr;
      next_cycle();
      data = data_o;
   endtask

   task automatic bus_write(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data,
                            output int stall_cycles);
      memen_i = 1'b1;
      dbin_i  = 1'b0;
      we_i    = 1'b1;
      addr_i  = addr;
      data_i  = data;
      next_cycle();
      stall_cycles = 0;
      while (ready_o !== 1'b1 && stall_cycles < 4 * SOUND_DIV) begin
         stall_cycles++;
         next_cycle();
      end
      if (ready_o !== 1'b1) begin
         report_error("ready_o never returned high during a write");
      end
      bus_idle();
      next_cycle(); // strobe low for a cycle so the next write arms the stall
   endtask

   function automatic logic [7:0] latch_byte(input int ch, input sound_reg_t kind, input int value);
      return {1'b1, 2'(ch), 1'(kind), 4'(value)};
   endfunction

   function automatic logic [7:0] data_byte(input int value);
      return {2'b00, 6'(value)};
   endfunction

   task automatic sound_write(input logic [7:0] sound_byte);
      int stall;
      bus_write(ADDR_BITS'($urandom_range(SOUND_LIMIT, SOUND_BASE)),
                {sound_byte, 8'($urandom())}, stall);
      if (stall < 1 || stall > SOUND_DIV) begin
         report_error($sformatf("sound write stalled %0d cycles, not 1 to %0d", stall, SOUND_DIV));
      end
   endtask

   task automatic test_reset();
      int cycles;
      repeat (10) next_cycle();
      check_bit("sys_reset_o", 1'b1, sys_reset_o);
      check_bit("ready_o", 1'b1, ready_o);
      check_word("data_o", 16'hFFFF, data_o);
      check_audio("audio_o", '0, audio_o);
      reset_i = 1'b0;
      cycles  = 0;
      while (sys_reset_o !== 1'b0 && cycles < 4 * RESET_SYNC) begin
         next_cycle();
         cycles++;
      end
      if (sys_reset_o !== 1'b0) begin
         report_error("sys_reset_o did not fall after reset_i was released");
      end else if (cycles != RESET_SYNC) begin
         report_error($sformatf("sys_reset_o fell after %0d cycles, not %0d", cycles, RESET_SYNC));
      end
      check_bit("ready_o", 1'b1, ready_o);
      check_word("data_o", 16'hFFFF, data_o);
      check_audio("audio_o", '0, audio_o);
      for (int k = 1; k <= 4 * CPU_DIV; k++) begin
         next_cycle();
         check_bit("cpu_clk_en_o", (k % CPU_DIV) == 0, cpu_clk_en_o);
      end
   endtask

   task automatic test_rom();
      logic [ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0] data;
      for (int i = 0; i < 24; i++) begin
         addr = ADDR_BITS'($urandom_range(ROM_LIMIT, ROM_BASE));
         bus_read(addr, data);
         check_word($sformatf("data_o at 0x%h", addr), rom_image[addr % ROM_WORDS], data);
      end
      bus_read(15'h1000, data); // just past the ROM
      check_word("data_o at 0x1000", 16'hFFFF, data);
      bus_read(15'h7FFF, data);
      check_word("data_o at 0x7fff", 16'hFFFF, data);
      bus_idle();
      next_cycle();
   endtask

   task automatic test_scratchpad();
      int                   index_q [$];
      int                   stall;
      logic [ADDR_BITS-1:0] addr;
      logic [DATA_BITS-1:0] data;
      for (int i = 0; i < 16; i++) begin
         addr = ADDR_BITS'($urandom_range(RAM_LIMIT, RAM_BASE));
         data = DATA_BITS'($urandom());
         bus_write(addr, data, stall);
         check_word("ram write stall cycles", '0, DATA_BITS'(stall));
         check_bit("ready_o", 1'b1, ready_o);
         ram_shadow[addr % RAM_WORDS] = data;
         index_q.push_back(addr % RAM_WORDS);
      end
      // one word per cycle through random mirrors
      foreach (index_q[i]) begin
         addr = ADDR_BITS'(RAM_BASE + index_q[i] + RAM_WORDS * $urandom_range(3, 0));
         bus_read(addr, data);
         check_word($sformatf("data_o at 0x%h", addr), ram_shadow[index_q[i]], data);
         check_bit("ready_o", 1'b1, ready_o);
      end
      bus_idle();
      next_cycle();
   endtask

   task automatic test_sound_stall();
      logic [DATA_BITS-1:0] data;
      for (int i = 0; i < 6; i++) begin
         repeat ($urandom_range(SOUND_DIV - 1, 0)) next_cycle(); // vary the enable phase
         sound_write(latch_byte(2, SR_ATTEN, 15));
      end
      sound_write(latch_byte(3, SR_ATTEN, 0)); // no noise channel
      check_audio("audio_o", '0, audio_o);
      bus_read(ADDR_BITS'(SOUND_BASE + 5), data);
      check_word("data_o at sound", 16'hFFFF, data);
      bus_idle();
      next_cycle();
   endtask

   task automatic test_tone();
      int atten;
      int period;
      atten  = $urandom_range(14, 0);
      period = $urandom_range(20, 2);
      sound_write(latch_byte(0, SR_ATTEN, 15));
      sound_write(latch_byte(2, SR_ATTEN, 15));
      sound_write(latch_byte(1, SR_ATTEN, atten));
      sound_write(latch_byte(1, SR_TONE, period));
      sound_write(data_byte(period >> 4));
      measure_tone((15 - atten) * AMP_STEP, period);
      sound_write(latch_byte(1, SR_ATTEN, 15));
      for (int i = 0; i < 2 * period * SOUND_DIV; i++) begin
         check_audio("audio_o", '0, audio_o);
         next_cycle();
      end
   endtask

   task automatic test_mixing();
      int atten;
      int expected;
      expected = 0;
      for (int ch = 0; ch < NUM_TONES; ch++) begin
         sound_write(latch_byte(ch, SR_TONE, 0));
         sound_write(data_byte(0));
      end
      // audible levels so a stray period write would show up as a sign flip
      for (int ch = 0; ch < NUM_TONES; ch++) begin
         atten = $urandom_range(14, 0);
         expected += (15 - atten) * AMP_STEP;
         sound_write(latch_byte(ch, SR_ATTEN, atten));
      end
      next_cycle();
      check_audio("audio_o", AUDIO_BITS'(expected), audio_o);
      sound_write(data_byte(6'h2A)); // latch still on an attenuation
      for (int i = 0; i < 2 * SOUND_DIV; i++) begin
         check_audio("audio_o", AUDIO_BITS'(expected), audio_o);
         next_cycle();
      end
   endtask

   initial begin
      void'($urandom(32'hb66cdc65));
      reset_i = 1'b1;
      addr_i  = '0;
      data_i  = '0;
      bus_idle();
      $readmemh("console_rom.hex", rom_image);
      test_reset();
      test_rom();
      test_scratchpad();
      test_sound_stall();
      test_tone();
      test_mixing();
      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* console_board.sv */
`timescale 1ns/1ns

module console_board
   import console_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset_i,
   input  logic                         memen_i,
   input  logic                         dbin_i,
   input  logic                         we_i,
   input  logic [ADDR_BITS-1:0]         addr_i,
   input  logic [DATA_BITS-1:0]         data_i,
   output logic [DATA_BITS-1:0]         data_o,
   output logic signed [AUDIO_BITS-1:0] audio_o,
   output logic                         ready_o,
   output logic                         sys_reset_o,
   output logic                         cpu_clk_en_o
);

   logic                 sys_reset;
   logic                 sound_clk_en;

   logic                 rom_sel;
   logic                 ram_sel;
   logic                 sound_sel;

   logic [DATA_BITS-1:0] rom_q;
   logic [DATA_BITS-1:0] ram_q;
   logic                 rom_valid;
   logic                 ram_valid;

   assign sys_reset_o = sys_reset;

   clock_enable_gen clock_enable_gen_i (
      .clk            (clk),
      .reset_i        (reset_i),
      .sys_reset_o    (sys_reset),
      .cpu_clk_en_o   (cpu_clk_en_o),
      .sound_clk_en_o (sound_clk_en)
   );

   address_decoder address_decoder_i (
      .memen_i     (memen_i),
      .we_i        (we_i),
      .addr_i      (addr_i),
      .rom_sel_o   (rom_sel),
      .ram_sel_o   (ram_sel),
      .sound_sel_o (sound_sel)
   );

   console_rom console_rom_i (
      .clk    (clk),
      .sel_i  (rom_sel),
      .addr_i (addr_i),
      .q_o    (rom_q)
   );

   scratchpad_ram scratchpad_ram_i (
      .clk    (clk),
      .sel_i  (ram_sel),
      .we_i   (we_i),
      .addr_i (addr_i),
      .data_i (data_i),
      .q_o    (ram_q)
   );

   tone_generator tone_generator_i (
      .clk      (clk),
      .reset_i  (sys_reset),
      .clk_en_i (sound_clk_en),
      .sel_i    (sound_sel),
      .byte_i   (data_i[15:8]), // sound chip sits on the high byte
      .ready_o  (ready_o),
      .audio_o  (audio_o)
   );

   // valids line up with the registered memory outputs
   always_ff @(posedge clk) begin
      if (sys_reset) begin
         rom_valid <= 1'b0;
         ram_valid <= 1'b0;
      end else begin
         rom_valid <= dbin_i && rom_sel;
         ram_valid <= dbin_i && ram_sel;
      end
   end

   // idle sources float high
   assign data_o = {DATA_BITS{1'b1}} &
                   (rom_valid ? rom_q : {DATA_BITS{1'b1}}) &
                   (ram_valid ? ram_q : {DATA_BITS{1'b1}});

endmodule

/* tone_generator.sv */
`timescale 1ns/1ns

module tone_generator
   import console_pkg::*;
(
   input  logic                         clk,
   input  logic                         reset_i,
   input  logic                         clk_en_i,
   input  logic                         sel_i,
   input  logic [7:0]                   byte_i,
   output logic                         ready_o,
   output logic signed [AUDIO_BITS-1:0] audio_o
);

   stall_state_t state;
   logic         sel_q;
   logic         apply;

   logic [1:0]   latch_ch;
   sound_reg_t   latch_reg;
   logic [1:0]   byte_ch;
   sound_reg_t   byte_reg;

   logic [PERIOD_BITS-1:0] period [NUM_TONES];
   logic [ATTEN_BITS-1:0]  atten [NUM_TONES];
   logic [PERIOD_BITS-1:0] count [NUM_TONES];
   logic [NUM_TONES-1:0]   neg; // 1 = negative half of the square wave

   logic signed [AUDIO_BITS-1:0] amp [NUM_TONES];
   logic signed [AUDIO_BITS-1:0] mix;

   assign ready_o  = (state == ST_IDLE);
   assign apply    = (state == ST_WAIT) && clk_en_i;
   assign byte_ch  = byte_i[6:5];
   assign byte_reg = sound_reg_t'(byte_i[4]);

   // bus stall, arms only on a new select
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state <= ST_IDLE;
         sel_q <= 1'b0;
      end else begin
         sel_q <= sel_i;
         case (state)
            ST_IDLE: begin
               if (sel_i && !sel_q) begin
                  state <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (clk_en_i) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         latch_ch  <= '0;
         latch_reg <= SR_TONE;
         for (int i = 0; i < NUM_TONES; i++) begin
            period[i] <= '0;
            atten[i]  <= ATTEN_SILENT;
         end
      end else if (apply) begin
         if (byte_i[7]) begin
            latch_ch  <= byte_ch;
            latch_reg <= byte_reg;
            if (byte_ch < NUM_TONES) begin // noise channel not present
               if (byte_reg == SR_ATTEN) begin
                  atten[byte_ch] <= byte_i[3:0];
               end else begin
                  period[byte_ch][3:0] <= byte_i[3:0];
               end
            end
         end else if (latch_reg == SR_TONE && latch_ch < NUM_TONES) begin
            period[latch_ch][PERIOD_BITS-1:4] <= byte_i[5:0];
         end
      end
   end

   // each half period lasts period ticks of clk_en_i
   always_ff @(posedge clk) begin
      if (reset_i) begin
         neg <= '0;
         for (int i = 0; i < NUM_TONES; i++) begin
            count[i] <= '0;
         end
      end else if (clk_en_i) begin
         for (int i = 0; i < NUM_TONES; i++) begin
            if (period[i] == '0) begin
               neg[i]   <= 1'b0;
               count[i] <= '0;
            end else if (count[i] <= PERIOD_BITS'(1)) begin
               count[i] <= period[i];
               neg[i]   <= ~neg[i];
            end else begin
               count[i] <= count[i] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      mix = '0;
      for (int i = 0; i < NUM_TONES; i++) begin
         amp[i] = AUDIO_BITS'(int'(ATTEN_SILENT - atten[i]) * AMP_STEP);
         mix    = neg[i] ? mix - amp[i] : mix + amp[i];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         audio_o <= '0;
      end else begin
         audio_o <= mix;
      end
   end

endmodule

/* scratchpad_ram.sv */
`timescale 1ns/1ns

module scratchpad_ram
   import console_pkg::*;
(
   input  logic                 clk,
   input  logic                 sel_i,
   input  logic                 we_i,
   input  logic [ADDR_BITS-1:0] addr_i,
   input  logic [DATA_BITS-1:0] data_i,
   output logic [DATA_BITS-1:0] q_o
);

   logic [DATA_BITS-1:0]     mem [RAM_WORDS];
   logic [RAM_ADDR_BITS-1:0] index;

   assign index = addr_i[RAM_ADDR_BITS-1:0]; // mirrored

   always_ff @(posedge clk) begin
      if (sel_i) begin
         if (we_i) begin
            mem[index] <= data_i;
         end else begin
            q_o <= mem[index];
         end
      end
   end

endmodule

/* console_rom.sv */
`timescale 1ns/1ns

module console_rom
   import console_pkg::*;
(
   input  logic                 clk,
   input  logic                 sel_i,
   input  logic [ADDR_BITS-1:0] addr_i,
   output logic [DATA_BITS-1:0] q_o
);

   logic [DATA_BITS-1:0] mem [ROM_WORDS];

   initial begin
      $readmemh("console_rom.hex", mem);
   end

   // low address bits only, so the image repeats over the region
   always_ff @(posedge clk) begin
      if (sel_i) begin
         q_o <= mem[addr_i[ROM_ADDR_BITS-1:0]];
      end
   end

endmodule

/* address_decoder.sv */
`timescale 1ns/1ns

module address_decoder
   import console_pkg::*;
(
   input  logic                 memen_i,
   input  logic                 we_i,
   input  logic [ADDR_BITS-1:0] addr_i,
   output logic                 rom_sel_o,
   output logic                 ram_sel_o,
   output logic                 sound_sel_o
);

   bus_region_t region;
   logic        in_rom;
   logic        in_ram;
   logic        in_sound;

   assign in_rom   = (addr_i >= ROM_BASE) && (addr_i <= ROM_LIMIT);
   assign in_ram   = (addr_i >= RAM_BASE) && (addr_i <= RAM_LIMIT);
   assign in_sound = (addr_i >= SOUND_BASE) && (addr_i <= SOUND_LIMIT);

   always_comb begin
      if (in_rom) begin
         region = REGION_ROM;
      end else if (in_ram) begin
         region = REGION_SCRATCH;
      end else if (in_sound) begin
         region = REGION_SOUND;
      end else begin
         region = REGION_NONE;
      end
   end

   assign rom_sel_o = memen_i && (region == REGION_ROM);
   assign ram_sel_o = memen_i && (region == REGION_SCRATCH);

   // sound chip is write only, reads fall through to the pull-up
   assign sound_sel_o = memen_i && we_i && (region == REGION_SOUND);

endmodule

/* clock_enable_gen.sv */
`timescale 1ns/1ns

module clock_enable_gen
   import console_pkg::*;
(
   input  logic clk,
   input  logic reset_i,
   output logic sys_reset_o,
   output logic cpu_clk_en_o,
   output logic sound_clk_en_o
);

   logic [RESET_SYNC-1:0]     reset_sync;
   logic [CPU_CNT_BITS-1:0]   cpu_cnt;
   logic [SOUND_CNT_BITS-1:0] sound_cnt;

   // reset_i may arrive from outside the clock domain
   always_ff @(posedge clk) begin
      reset_sync <= {reset_sync[RESET_SYNC-2:0], reset_i};
   end

   assign sys_reset_o = reset_sync[RESET_SYNC-1];

   // enable pulse registered, first one CPU_DIV cycles after reset
   always_ff @(posedge clk) begin
      if (sys_reset_o) begin
         cpu_cnt      <= '0;
         cpu_clk_en_o <= 1'b0;
      end else begin
         cpu_clk_en_o <= (cpu_cnt == CPU_CNT_BITS'(CPU_DIV - 1));
         cpu_cnt      <= (cpu_cnt == CPU_CNT_BITS'(CPU_DIV - 1)) ? '0 : cpu_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sys_reset_o) begin
         sound_cnt      <= '0;
         sound_clk_en_o <= 1'b0;
      end else begin
         sound_clk_en_o <= (sound_cnt == SOUND_CNT_BITS'(SOUND_DIV - 1));
         sound_cnt      <= sound_cnt + 1'b1; // power of two, wraps by itself
      end
   end

endmodule

/* console_pkg.sv */
package console_pkg;

   // bus and sample widths
   localparam int ADDR_BITS  = 15;
   localparam int DATA_BITS  = 16;
   localparam int AUDIO_BITS = 16;

   // memory sizes, both mirrored across their regions
   localparam int ROM_WORDS     = 64;
   localparam int RAM_WORDS     = 128;
   localparam int ROM_ADDR_BITS = $clog2(ROM_WORDS);
   localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

   // word address map
   localparam logic [ADDR_BITS-1:0] ROM_BASE    = 15'h0000;
   localparam logic [ADDR_BITS-1:0] ROM_LIMIT   = 15'h0FFF;
   localparam logic [ADDR_BITS-1:0] RAM_BASE    = 15'h4000;
   localparam logic [ADDR_BITS-1:0] RAM_LIMIT   = 15'h41FF;
   localparam logic [ADDR_BITS-1:0] SOUND_BASE  = 15'h4200;
   localparam logic [ADDR_BITS-1:0] SOUND_LIMIT = 15'h42FF;

   // clock enable dividers
   localparam int CPU_DIV        = 3;
   localparam int SOUND_DIV      = 16;
   localparam int CPU_CNT_BITS   = $clog2(CPU_DIV);
   localparam int SOUND_CNT_BITS = $clog2(SOUND_DIV);

   localparam int RESET_SYNC = 2;

   // sound generator
   localparam int NUM_TONES   = 3;
   localparam int PERIOD_BITS = 10;
   localparam int ATTEN_BITS  = 4;
   localparam logic [ATTEN_BITS-1:0] ATTEN_SILENT = 4'd15;
   localparam int AMP_STEP = 512; // amplitude = (15 - atten) * AMP_STEP

   typedef enum logic [1:0] {
      REGION_NONE,
      REGION_ROM,
      REGION_SCRATCH,
      REGION_SOUND
   } bus_region_t;

   typedef enum logic {
      SR_TONE,
      SR_ATTEN
   } sound_reg_t;

   typedef enum logic {
      ST_IDLE,
      ST_WAIT
   } stall_state_t;

endpackage
